// File: build.f
+incdir+source
source/fp_pkg.sv
source/fp_lzc.sv
source/fp_align.sv
source/fp_sum_normalize.sv
source/fp_add_pipe.sv
sim/fp_add_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the FP adder testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module fp_add_tb \
    -o fp_add_sim \
    && ./obj_dir/fp_add_sim \
    || { echo "simulation did not complete successfully"; exit 1; }

exit 0

// File: sim/fp_add_tb.sv
// Self-checking testbench for the FP adder pipeline; run with the top module fp_add_tb
`timescale 1ns/10ps
`include "fp_defines.svh"

module fp_add_tb import fp_pkg::*; ();

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 10;
    localparam int LATENCY       = `FP_LATENCY;
    localparam int EXP_W         = `FP_EXP_W;
    localparam int FRAC_W        = `FP_FRAC_W;
    localparam int EXP_MAX       = `FP_EXP_MAX;
    localparam int SIGN_BIT      = EXP_W + FRAC_W;
    localparam int NUM_DIRECTED  = 24;
    localparam int NUM_RANDOM    = 2000;
    localparam int MARGIN_CYCLES = 100;

    // Fill pairs, directed, random, drain pairs and the final settle cycles
    localparam int TOTAL_CYCLES  = RESET_CYCLES + LATENCY + NUM_DIRECTED + NUM_RANDOM
                                 + LATENCY + 2;
    localparam int TIMEOUT_NS    = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    // Every popped entry is one compare, drain pairs stay in the queue
    localparam int EXPECTED_COMPARES = LATENCY + NUM_DIRECTED + NUM_RANDOM;

    typedef logic [FRAC_W-1:0] frac_t;

    // One operand pair and the sum the DUT should return for it
    typedef struct packed {
        fp32_t a;
        fp32_t b;
        fp32_t expected;
    } vector_t;

    // Directed pairs, a in the upper word and b in the lower word
    localparam logic [63:0] DIRECTED [NUM_DIRECTED] = '{
        64'h3f800000_3f800000,  // 1.0 + 1.0, carry into bit 24
        64'h3fc00000_40200000,  // 1.5 + 2.5
        64'h3f800000_3f000000,  // 1.0 + 0.5
        64'h40400000_3f800000,  // 3.0 + 1.0, carry with unequal exponents
        64'h4b7fffff_4b7fffff,  // all-ones mantissas, carry
        64'h3f800000_bf800000,  // exact cancellation
        64'h3f800000_bf7fffff,  // large left shift
        64'hc0a00000_40000000,  // negative operand is larger
        64'h40000000_c0a00000,  // same, swapped order
        64'h3f800001_bf800000,  // single LSB left, shift by 23
        64'h3f800000_bfc00000,  // equal exponents, b larger
        64'h4b800000_3f800000,  // exponent difference of 24
        64'h3f800000_4c000000,  // exponent difference of 25
        64'hd9000000_3f800000,  // tiny operand vanishes
        64'h00400000_40490fdb,  // zero exponent with nonzero fraction
        64'h80000000_c0000000,  // negative zero plus negative value
        64'h7f7fffff_7f7fffff,  // overflow to positive infinity
        64'hff7fffff_ff7fffff,  // overflow to negative infinity
        64'h7f000000_7f000000,  // overflow from the carry alone
        64'h00c00000_80800000,  // underflow at the minimum exponent
        64'h80c00000_00800000,  // underflow with a negative larger operand
        64'h01000000_80800000,  // lands exactly on exponent 1
        64'h80000000_80000000,  // both negative zero
        64'h00800001_80800000   // LSB left at the minimum exponent
    };

    logic  clk;
    logic  reset;
    fp32_t a;
    fp32_t b;
    fp32_t result;

    logic [31:0] lfsr_state;
    vector_t     exp_q [$];
    vector_t     popped;
    int          compared;

    fp_add_pipe UUT (
        .clk    (clk),
        .reset  (reset),
        .a      (a),
        .b      (b),
        .result (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // One LFSR step per returned bit, newest bit at the bottom
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Expected sum with truncation, flush to zero and saturation to infinity
    function automatic fp32_t fp_add_ref(input fp32_t x, input fp32_t y);
        fp32_t big_op;
        fp32_t small_op;
        int    big_e;
        int    small_e;
        int    big_m;
        int    small_m;
        int    s;
        int    e;
        if ((x[SIGN_BIT-1:FRAC_W] > y[SIGN_BIT-1:FRAC_W]) ||
            ((x[SIGN_BIT-1:FRAC_W] == y[SIGN_BIT-1:FRAC_W]) &&
             (x[FRAC_W-1:0] > y[FRAC_W-1:0]))) begin
            big_op   = x;
            small_op = y;
        end else begin
            big_op   = y;
            small_op = x;
        end
        big_e   = int'(big_op[SIGN_BIT-1:FRAC_W]);
        small_e = int'(small_op[SIGN_BIT-1:FRAC_W]);
        big_m   = (big_e == 0) ? 0 : int'({1'b1, big_op[FRAC_W-1:0]});
        small_m = (small_e == 0) ? 0 : int'({1'b1, small_op[FRAC_W-1:0]});
        if (big_e - small_e > FRAC_W) begin
            small_m = 0;
        end else begin
            small_m = small_m >> (big_e - small_e);
        end
        if (big_op[SIGN_BIT] != small_op[SIGN_BIT]) begin
            s = big_m - small_m;
        end else begin
            s = big_m + small_m;
        end
        if (s == 0) begin
            return '0;
        end
        e = big_e;
        if (s >= (1 << (FRAC_W + 1))) begin
            s = s >> 1;
            e = e + 1;
        end else begin
            while (s < (1 << FRAC_W)) begin
                s = s << 1;
                e = e - 1;
            end
        end
        if (e >= EXP_MAX) begin
            return {big_op[SIGN_BIT], fp_exp_t'(EXP_MAX), {FRAC_W{1'b0}}};
        end
        if (e <= 0) begin
            return '0;
        end
        return {big_op[SIGN_BIT], e[EXP_W-1:0], s[FRAC_W-1:0]};
    endfunction

    task automatic check_fp32(input string name, input fp32_t actual, input fp32_t expected,
                              input fp32_t x, input fp32_t y);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h (a %h b %h) at %0d ns",
                     name, expected, actual, x, y, $time);
            $display("TESTBENCH FAILED");
            $fatal(1, "value compare failed");
        end
    endtask

    // Known IEEE sums, so a broken reference cannot hide a broken DUT
    task automatic check_reference();
        check_fp32("fp_add_ref", fp_add_ref(32'h3f800000, 32'h3f800000), 32'h40000000,
                   32'h3f800000, 32'h3f800000);
        check_fp32("fp_add_ref", fp_add_ref(32'h3f800000, 32'hbf800000), 32'h00000000,
                   32'h3f800000, 32'hbf800000);
        check_fp32("fp_add_ref", fp_add_ref(32'hc0a00000, 32'h40000000), 32'hc0400000,
                   32'hc0a00000, 32'h40000000);
        check_fp32("fp_add_ref", fp_add_ref(32'h7f7fffff, 32'h7f7fffff), 32'h7f800000,
                   32'h7f7fffff, 32'h7f7fffff);
        check_fp32("fp_add_ref", fp_add_ref(32'h00c00000, 32'h80800000), 32'h00000000,
                   32'h00c00000, 32'h80800000);
        check_fp32("fp_add_ref", fp_add_ref(32'h4b800000, 32'h3f800000), 32'h4b800000,
                   32'h4b800000, 32'h3f800000);
    endtask

    // Exponent 255 is never produced, so no NaN or infinity reaches the DUT
    task automatic make_random_pair(output fp32_t x, output fp32_t y);
        logic    sa;
        logic    sb;
        fp_exp_t ea;
        fp_exp_t eb;
        frac_t   fa;
        frac_t   fb;
        logic    near;
        sa   = 1'(random_bits(1));
        ea   = fp_exp_t'(random_bits(EXP_W));
        fa   = frac_t'(random_bits(FRAC_W));
        sb   = 1'(random_bits(1));
        fb   = frac_t'(random_bits(FRAC_W));
        near = 1'(random_bits(1));
        // Close exponents half the time, for carries and cancellations
        if (near) begin
            eb = ea ^ fp_exp_t'(random_bits(2));
        end else begin
            eb = fp_exp_t'(random_bits(EXP_W));
        end
        if (ea == fp_exp_t'(EXP_MAX)) begin
            ea = fp_exp_t'(EXP_MAX - 1);
        end
        if (eb == fp_exp_t'(EXP_MAX)) begin
            eb = fp_exp_t'(EXP_MAX - 1);
        end
        x = {sa, ea, fa};
        y = {sb, eb, fb};
    endtask

    task automatic drive_pair(input fp32_t x, input fp32_t y);
        vector_t v;
        @(posedge clk);
        a <= x;
        b <= y;
        v.a        = x;
        v.b        = y;
        v.expected = fp_add_ref(x, y);
        exp_q.push_back(v);
    endtask

    // Three pairs in flight, so the oldest entry is due once a fourth is queued
    always @(negedge clk) begin
        if (!reset) begin
            if (exp_q.size() > LATENCY) begin
                popped = exp_q.pop_front();
                check_fp32("result", result, popped.expected, popped.a, popped.b);
                compared++;
            end else begin
                // Pipeline still holds reset or fill zeros
                check_fp32("result", result, '0, '0, '0);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: timeout after %0d ns, the test sequence did not finish", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        fp32_t ra;
        fp32_t rb;
        clk        = 1'b0;
        reset      = 1'b1;
        a          = '0;
        b          = '0;
        compared   = 0;
        lfsr_state = 32'hc6ccea0a;

        check_reference();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Zero pairs first, result must stay zero until the first real pair
        repeat (LATENCY) drive_pair('0, '0);

        for (int i = 0; i < NUM_DIRECTED; i++) begin
            drive_pair(DIRECTED[i][63:32], DIRECTED[i][31:0]);
        end

        // Back-to-back random pairs, one per clock
        for (int i = 0; i < NUM_RANDOM; i++) begin
            make_random_pair(ra, rb);
            drive_pair(ra, rb);
        end

        // Drain pairs push the last random results out
        repeat (LATENCY) drive_pair('0, '0);
        repeat (2) @(negedge clk);

        if ((compared != EXPECTED_COMPARES) || (exp_q.size() != LATENCY)) begin
            $display("ERROR: %0d results compared, %0d expected, %0d left in queue",
                     compared, EXPECTED_COMPARES, exp_q.size());
            $display("TESTBENCH FAILED");
            $fatal(1, "result count wrong");
        end else begin
            $display("%0d results compared", compared);
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: source/fp_add_pipe.sv
// Top of the three-cycle single-precision adder pipeline, one operand pair in and one result out per clock
`timescale 1ns/10ps

module fp_add_pipe import fp_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  fp32_t a,
    input  fp32_t b,
    output fp32_t result
);

    fp32_t        a_q;
    fp32_t        b_q;
    aligned_ops_t aligned;

    // Input operand stage, first of the three pipeline registers
    always_ff @(posedge clk) begin
        if (reset) begin
            a_q <= '0;
            b_q <= '0;
        end else begin
            a_q <= a;
            b_q <= b;
        end
    end

    // Unpack, order and align
    fp_align u_align (
        .clk     (clk),
        .reset   (reset),
        .a_q     (a_q),
        .b_q     (b_q),
        .aligned (aligned)
    );

    // Add, normalize and pack
    fp_sum_normalize u_sum_normalize (
        .clk     (clk),
        .reset   (reset),
        .aligned (aligned),
        .result  (result)
    );

endmodule

// File: source/fp_sum_normalize.sv
// Second compute stage of the FP adder, adds the aligned mantissas, normalizes and packs the result
`timescale 1ns/10ps
`include "fp_defines.svh"

module fp_sum_normalize import fp_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  aligned_ops_t aligned,
    output fp32_t        result
);

    // Two extra bits so both overflow and underflow stay visible
    localparam int EXP_WIDE_W = `FP_EXP_W + 2;
    localparam int EXP_MAX    = `FP_EXP_MAX;

    fp_sum_t                       sum;
    fp_sum_t                       norm_sum;
    logic [4:0]                    lz_count;
    logic [4:0]                    shift_left;
    logic signed [EXP_WIDE_W-1:0]  exp_wide;
    fp32_t                         result_next;
    fp_exp_t                       result_exp;

    // Effective add or subtract, big_mant is never smaller than small_mant
    always_comb begin
        if (aligned.eff_sub) begin
            sum = {1'b0, aligned.big_mant} - {1'b0, aligned.small_mant};
        end else begin
            sum = {1'b0, aligned.big_mant} + {1'b0, aligned.small_mant};
        end
    end

    fp_lzc u_lzc (
        .sum      (sum),
        .lz_count (lz_count)
    );

    // One leading zero means bit 23 is already set
    assign shift_left = lz_count - 5'd1;

    // Carry out shifts right once, otherwise shift left up to bit 23
    always_comb begin
        if (sum[`FP_FRAC_W + 1]) begin
            norm_sum = sum >> 1;
            exp_wide = $signed({2'b00, aligned.big_exp}) + 10'sd1;
        end else begin
            norm_sum = sum << shift_left;
            exp_wide = $signed({2'b00, aligned.big_exp})
                     - $signed({{(EXP_WIDE_W - 5){1'b0}}, shift_left});
        end
    end

    // Zero and underflow both give +0, overflow saturates to infinity
    always_comb begin
        if (sum == '0) begin
            result_next = '0;
        end else if (exp_wide >= EXP_MAX) begin
            result_next = {aligned.result_sign, fp_exp_t'(EXP_MAX), {`FP_FRAC_W{1'b0}}};
        end else if (exp_wide <= 0) begin
            result_next = '0;
        end else begin
            result_next = {aligned.result_sign,
                           exp_wide[`FP_EXP_W-1:0],
                           norm_sum[`FP_FRAC_W-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= result_next;
        end
    end

    assign result_exp = result[`FP_EXP_W + `FP_FRAC_W - 1 : `FP_FRAC_W];

    // Any nonzero exponent came from a sum whose hidden bit landed on bit 23
    normalized_when_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        (result_exp != '0) |-> $past(norm_sum[`FP_FRAC_W])
    );

    // Saturation only ever produces infinity, never a NaN pattern
    no_nan_output: assert property (
        @(posedge clk) disable iff (reset)
        (result_exp == fp_exp_t'(EXP_MAX)) |-> (result[`FP_FRAC_W-1:0] == '0)
    );

endmodule

// File: source/fp_align.sv
// First compute stage of the FP adder, unpacks, orders by magnitude and aligns the smaller operand
`timescale 1ns/10ps
`include "fp_defines.svh"

module fp_align import fp_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  fp32_t        a_q,
    input  fp32_t        b_q,
    output aligned_ops_t aligned
);

    // Shift distance at which the smaller mantissa is gone entirely
    localparam int MANT_W = `FP_FRAC_W + 1;

    logic                   a_sign;
    logic                   b_sign;
    fp_exp_t                a_exp;
    fp_exp_t                b_exp;
    logic [`FP_FRAC_W-1:0]  a_frac;
    logic [`FP_FRAC_W-1:0]  b_frac;
    fp_mant_t               a_mant;
    fp_mant_t               b_mant;
    logic                   a_is_big;
    fp_exp_t                big_exp;
    fp_exp_t                small_exp;
    fp_mant_t               small_mant_raw;
    fp_exp_t                exp_diff;
    aligned_ops_t           aligned_next;

    // Field unpack
    assign a_sign = a_q[`FP_EXP_W + `FP_FRAC_W];
    assign b_sign = b_q[`FP_EXP_W + `FP_FRAC_W];
    assign a_exp  = a_q[`FP_EXP_W + `FP_FRAC_W - 1 : `FP_FRAC_W];
    assign b_exp  = b_q[`FP_EXP_W + `FP_FRAC_W - 1 : `FP_FRAC_W];
    assign a_frac = a_q[`FP_FRAC_W - 1 : 0];
    assign b_frac = b_q[`FP_FRAC_W - 1 : 0];

    // No denormals, a zero exponent reads as zero
    assign a_mant = (a_exp != '0) ? {1'b1, a_frac} : '0;
    assign b_mant = (b_exp != '0) ? {1'b1, b_frac} : '0;

    // Exponent decides first, fraction breaks a tie
    // On a full tie b is taken, harmless since the result is then exact
    assign a_is_big = (a_exp > b_exp) || ((a_exp == b_exp) && (a_frac > b_frac));

    assign big_exp        = a_is_big ? a_exp : b_exp;
    assign small_exp      = a_is_big ? b_exp : a_exp;
    assign small_mant_raw = a_is_big ? b_mant : a_mant;
    assign exp_diff       = big_exp - small_exp;

    always_comb begin
        aligned_next.result_sign = a_is_big ? a_sign : b_sign;
        aligned_next.eff_sub     = a_sign ^ b_sign;
        aligned_next.big_exp     = big_exp;
        aligned_next.big_mant    = a_is_big ? a_mant : b_mant;
        // Bits shifted out are simply dropped, truncation rounding
        if (exp_diff >= fp_exp_t'(MANT_W)) begin
            aligned_next.small_mant = '0;
        end else begin
            aligned_next.small_mant = small_mant_raw >> exp_diff;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aligned <= '0;
        end else begin
            aligned <= aligned_next;
        end
    end

    // Registered exponent is never below the smaller input exponent of the cycle before
    big_exp_ordered: assert property (
        @(posedge clk) disable iff (reset)
        1'b1 |=> (aligned.big_exp >= $past(small_exp))
    );

endmodule

// File: source/fp_lzc.sv
// Leading-zero counter over the 25-bit mantissa sum, feeds the shift amount of the normalize stage
`timescale 1ns/10ps
`include "fp_defines.svh"

module fp_lzc import fp_pkg::*; (
    input  fp_sum_t    sum,
    output logic [4:0] lz_count
);

    // Index of the sum's top bit
    localparam int TOP = `FP_FRAC_W + 1;

    always_comb begin
        // All-zero input falls through to the full width
        lz_count = 5'(TOP + 1);
        // Scan upward so the highest set bit wins
        for (int i = 0; i <= TOP; i++) begin
            if (sum[i]) begin
                lz_count = 5'(TOP - i);
            end
        end
    end

endmodule

// File: source/fp_pkg.sv
// Shared field types for the floating-point adder pipeline, imported by every RTL module
`include "fp_defines.svh"

package fp_pkg;

    // Full IEEE single word, sign then exponent then fraction
    typedef logic [`FP_EXP_W + `FP_FRAC_W : 0] fp32_t;

    // Biased exponent
    typedef logic [`FP_EXP_W - 1 : 0] fp_exp_t;

    // Mantissa with the hidden bit made explicit at the top
    typedef logic [`FP_FRAC_W : 0] fp_mant_t;

    // Mantissa sum, one carry bit above fp_mant_t
    typedef logic [`FP_FRAC_W + 1 : 0] fp_sum_t;

    // Operands after ordering and alignment, ready for the mantissa add
    // big_mant always holds the larger magnitude, so the subtract never goes negative
    typedef struct packed {
        // Sign of the larger-magnitude operand
        logic     result_sign;
        // Signs differ, so the mantissas are subtracted
        logic     eff_sub;
        fp_exp_t  big_exp;
        fp_mant_t big_mant;
        // Already shifted right by the exponent difference
        fp_mant_t small_mant;
    } aligned_ops_t;

endpackage

// File: source/fp_defines.svh
// Format and latency constants for the single-precision adder, included by the package, RTL and testbench
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Biased exponent field width
`define FP_EXP_W 8

// Stored fraction width, hidden bit not included
`define FP_FRAC_W 23

// All-ones exponent, used as the infinity code on overflow
`define FP_EXP_MAX 255

// Cycles from input sampling to the registered result
// Input register, align stage, normalize stage
`define FP_LATENCY 3

`endif
